// ==== rtl/dram_geom_pkg.sv ====
//////////////////////////////
// Widths below track the default geometry constants
// A power of two is assumed for every geometry count
//////////////////////////////
package dram_geom_pkg;

    // Field order from MSB to LSB, byte offset always lowest
    typedef enum logic [1:0] {
        MAP_RO_RA_BG_BA_CO_CH,
        MAP_RO_RA_BG_BA_CH_CO,
        MAP_RO_CH_RA_BA_BG_CO
    } addr_map_e;

    localparam int NUM_CHANNELS = 2;
    localparam int NUM_ROWS     = 8;
    localparam int NUM_RANKS    = 1;  // Rank field collapses to zero bits
    localparam int NUM_BG       = 2;
    localparam int NUM_BA       = 2;
    localparam int NUM_COLUMNS  = 16;
    localparam int BYTE_OFF_W   = 2;  // 32-bit words

    function automatic int field_bits(int n);
        return (n > 1) ? $clog2(n) : 0;
    endfunction

    // Channel-local byte address width, channel field excluded
    function automatic int ch_addr_bits(int ro, int ra, int bg, int ba, int co);
        return field_bits(ro) + field_bits(ra) + field_bits(bg) + field_bits(ba)
            + field_bits(co) + BYTE_OFF_W;
    endfunction

    function automatic int glob_addr_bits(int ch, int ro, int ra, int bg, int ba, int co);
        return field_bits(ch) + ch_addr_bits(ro, ra, bg, ba, co);
    endfunction

    // Zero width gives a zero field
    function automatic int unsigned field_get(int unsigned addr, int pos, int w);
        return (addr >> pos) & ((32'd1 << w) - 32'd1);
    endfunction

    typedef logic [0:0]  ch_idx_t;
    typedef logic [10:0] ch_addr_t;
    typedef logic [11:0] glob_addr_t;

endpackage

// ==== rtl/wb_bus_pkg.sv ====
//////////////////////////////
// Wishbone classic, 32-bit data, byte addressed
//////////////////////////////
package wb_bus_pkg;

    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;
    localparam int WB_ADDR_W = 32;

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;   // One bit per byte lane
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;  // Byte address

endpackage

// ==== rtl/mem_req_if.sv ====
//////////////////////////////
// One request in flight at a time, so no ready signal
// req payload holds until rsp_valid
//////////////////////////////
`timescale 1ns/1ps

interface mem_req_if;
    import dram_geom_pkg::*;
    import wb_bus_pkg::*;

    // Front end to mapper and memory
    logic       req_valid;
    logic       req_we;
    glob_addr_t req_addr;
    wb_data_t   req_wdata;
    wb_sel_t    req_sel;

    // Mapper to memory
    logic     map_valid;
    ch_idx_t  map_ch;
    ch_addr_t map_addr;

    // Memory back to front end
    logic     rsp_valid;
    wb_data_t rsp_rdata;

    modport front (
        output req_valid, req_we, req_addr, req_wdata, req_sel,
        input  rsp_valid, rsp_rdata
    );

    modport mapper (
        input  req_valid, req_addr,
        output map_valid, map_ch, map_addr
    );

    modport memory (
        input  map_valid, map_ch, map_addr, req_we, req_wdata, req_sel,
        output rsp_valid, rsp_rdata
    );

endinterface

// ==== rtl/wb_slave_front.sv ====
//////////////////////////////
// Single transfers only, no burst or pipelined cycles
// Ack/err last one cycle, then one idle cycle before the next sample
//////////////////////////////
`timescale 1ns/1ps

module wb_slave_front (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  wb_bus_pkg::wb_addr_t wb_adr_i,
    input  wb_bus_pkg::wb_data_t wb_dat_i,
    input  wb_bus_pkg::wb_sel_t  wb_sel_i,
    output wb_bus_pkg::wb_data_t wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 wb_err_o,
    mem_req_if.front             mem
);
    import wb_bus_pkg::*;
    import dram_geom_pkg::*;

    localparam int GLOB_W = $bits(glob_addr_t);

    typedef enum logic [2:0] {IDLE, WAIT, ACK, ERR, GAP} front_state_e;

    front_state_e state_q;
    logic         take;
    logic         in_range;
    logic         oor_q;      // Captured transfer is out of range

    assign take     = (state_q == IDLE) && wb_cyc_i && wb_stb_i;
    assign in_range = (wb_adr_i[$bits(wb_addr_t)-1:GLOB_W] == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= IDLE;
            mem.req_valid <= 1'b0;
        end else begin
            mem.req_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (take) begin
                        state_q       <= WAIT;
                        mem.req_valid <= in_range;  // No request for a bad address
                    end
                end
                WAIT: begin
                    if (oor_q)
                        state_q <= ERR;
                    else if (mem.rsp_valid)
                        state_q <= ACK;
                end
                ACK, ERR: state_q <= GAP;
                GAP:      state_q <= IDLE;  // Keeps a held stb from being taken twice
                default:  state_q <= IDLE;
            endcase
        end
    end

    // Request payload, held until the response
    always_ff @(posedge clk_i) begin
        if (take) begin
            oor_q         <= !in_range;
            mem.req_we    <= wb_we_i;
            mem.req_addr  <= wb_adr_i[GLOB_W-1:0];
            mem.req_wdata <= wb_dat_i;
            mem.req_sel   <= wb_sel_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem.rsp_valid)
            wb_dat_o <= mem.rsp_rdata;
    end

    assign wb_ack_o = (state_q == ACK);
    assign wb_err_o = (state_q == ERR);

    // Master must keep cyc up while the slave terminates
    a_term_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wb_ack_o && wb_err_o) && ((wb_ack_o || wb_err_o) -> wb_cyc_i));

endmodule

// ==== rtl/addr_unmap.sv ====
//////////////////////////////
// Channel address packs ro, ra, bg, ba, co top down
// Rows always sit above every other field
//////////////////////////////
`timescale 1ns/1ps

module addr_unmap #(
    parameter dram_geom_pkg::addr_map_e MAPPING = dram_geom_pkg::MAP_RO_RA_BG_BA_CO_CH,
    parameter int NUM_CHANNELS = dram_geom_pkg::NUM_CHANNELS,
    parameter int NUM_COLUMNS  = dram_geom_pkg::NUM_COLUMNS,
    parameter int NUM_ROWS     = dram_geom_pkg::NUM_ROWS,
    parameter int NUM_BG       = dram_geom_pkg::NUM_BG,
    parameter int NUM_BA       = dram_geom_pkg::NUM_BA,
    parameter int NUM_RANKS    = dram_geom_pkg::NUM_RANKS
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    mem_req_if.mapper mem
);
    import dram_geom_pkg::*;

    localparam int CH_W = field_bits(NUM_CHANNELS);
    localparam int CO_W = field_bits(NUM_COLUMNS);
    localparam int RO_W = field_bits(NUM_ROWS);
    localparam int BG_W = field_bits(NUM_BG);
    localparam int BA_W = field_bits(NUM_BA);
    localparam int RA_W = field_bits(NUM_RANKS);
    localparam int BO_W = BYTE_OFF_W;

    localparam bit M1 = (MAPPING == MAP_RO_RA_BG_BA_CO_CH);
    localparam bit M2 = (MAPPING == MAP_RO_RA_BG_BA_CH_CO);
    localparam bit M3 = (MAPPING == MAP_RO_CH_RA_BA_BG_CO);

    // Field LSB positions in the global address
    localparam int CO_POS = M1 ? BO_W + CH_W : BO_W;
    localparam int CH_POS = M1 ? BO_W
                          : M2 ? BO_W + CO_W
                          : BO_W + CO_W + BG_W + BA_W + RA_W;
    localparam int BA_POS = M3 ? BO_W + CO_W + BG_W : BO_W + CH_W + CO_W;
    localparam int BG_POS = M3 ? BO_W + CO_W : BA_POS + BA_W;
    localparam int RA_POS = M3 ? BO_W + CO_W + BG_W + BA_W : BG_POS + BG_W;
    localparam int RO_POS = BO_W + CH_W + CO_W + BA_W + BG_W + RA_W;

    int unsigned ro_f, ra_f, bg_f, ba_f, co_f, ch_f;
    int unsigned packed_addr;

    assign ro_f = field_get(mem.req_addr, RO_POS, RO_W);
    assign ra_f = field_get(mem.req_addr, RA_POS, RA_W);
    assign bg_f = field_get(mem.req_addr, BG_POS, BG_W);
    assign ba_f = field_get(mem.req_addr, BA_POS, BA_W);
    assign co_f = field_get(mem.req_addr, CO_POS, CO_W);
    assign ch_f = field_get(mem.req_addr, CH_POS, CH_W);

    // Zero-width fields shift by nothing and add nothing
    assign packed_addr = ((((((ro_f << RA_W) | ra_f) << BG_W | bg_f) << BA_W | ba_f)
                         << CO_W | co_f) << BO_W);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            mem.map_valid <= 1'b0;
        else
            mem.map_valid <= mem.req_valid;
    end

    always_ff @(posedge clk_i) begin
        if (mem.req_valid) begin
            mem.map_ch   <= ch_idx_t'(ch_f);
            mem.map_addr <= ch_addr_t'(packed_addr);
        end
    end

    // A request is a single-cycle pulse and is mapped in the next cycle
    a_one_stage: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem.req_valid |=> (mem.map_valid && !mem.req_valid));

endmodule

// ==== rtl/channel_mem_array.sv ====
//////////////////////////////
// Word stores have no reset and start undefined
// Read data holds until the next read
//////////////////////////////
`timescale 1ns/1ps

module channel_mem_array #(
    parameter int NUM_CHANNELS = dram_geom_pkg::NUM_CHANNELS,
    parameter int NUM_COLUMNS  = dram_geom_pkg::NUM_COLUMNS,
    parameter int NUM_ROWS     = dram_geom_pkg::NUM_ROWS,
    parameter int NUM_BG       = dram_geom_pkg::NUM_BG,
    parameter int NUM_BA       = dram_geom_pkg::NUM_BA,
    parameter int NUM_RANKS    = dram_geom_pkg::NUM_RANKS
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    mem_req_if.memory               mem,
    output logic [NUM_CHANNELS-1:0] ch_act_o
);
    import dram_geom_pkg::*;
    import wb_bus_pkg::*;

    localparam int WORDS  = NUM_ROWS * NUM_RANKS * NUM_BG * NUM_BA * NUM_COLUMNS;
    localparam int WORD_W = field_bits(WORDS);

    wb_data_t           store [NUM_CHANNELS][WORDS];
    logic [WORD_W-1:0]  widx;

    assign widx = mem.map_addr[BYTE_OFF_W +: WORD_W];  // Byte offset dropped

    // Byte-lane merge on writes, read-back registered
    always_ff @(posedge clk_i) begin
        if (mem.map_valid) begin
            if (mem.req_we) begin
                for (int b = 0; b < $bits(wb_sel_t); b++) begin
                    if (mem.req_sel[b])
                        store[mem.map_ch][widx][8*b +: 8] <= mem.req_wdata[8*b +: 8];
                end
            end else begin
                mem.rsp_rdata <= store[mem.map_ch][widx];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem.rsp_valid <= 1'b0;
            ch_act_o      <= '0;
        end else begin
            mem.rsp_valid <= mem.map_valid;
            ch_act_o      <= '0;
            if (mem.map_valid)
                ch_act_o[mem.map_ch] <= 1'b1;  // Seen by the monitor one cycle before ack
        end
    end

    // One channel active per transfer, for a single cycle
    a_act_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem.map_valid |=> ($onehot(ch_act_o) && !mem.map_valid));

endmodule

// ==== rtl/dram_model_top.sv ====
//////////////////////////////
// Geometry must fit the package typedef widths
// No DRAM timing, fixed 4-cycle ack latency
//////////////////////////////
`timescale 1ns/1ps

module dram_model_top #(
    parameter dram_geom_pkg::addr_map_e MAPPING = dram_geom_pkg::MAP_RO_RA_BG_BA_CO_CH,
    parameter int NUM_CHANNELS = dram_geom_pkg::NUM_CHANNELS,
    parameter int NUM_COLUMNS  = dram_geom_pkg::NUM_COLUMNS,
    parameter int NUM_ROWS     = dram_geom_pkg::NUM_ROWS,
    parameter int NUM_BG       = dram_geom_pkg::NUM_BG,
    parameter int NUM_BA       = dram_geom_pkg::NUM_BA,
    parameter int NUM_RANKS    = dram_geom_pkg::NUM_RANKS
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  wb_bus_pkg::wb_addr_t    wb_adr_i,
    input  wb_bus_pkg::wb_data_t    wb_dat_i,
    input  wb_bus_pkg::wb_sel_t     wb_sel_i,
    output wb_bus_pkg::wb_data_t    wb_dat_o,
    output logic                    wb_ack_o,
    output logic                    wb_err_o,
    output logic [NUM_CHANNELS-1:0] ch_act_o
);
    import dram_geom_pkg::*;

    mem_req_if req_if ();

    wb_slave_front front_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .mem      (req_if.front)
    );

    addr_unmap #(
        .MAPPING(MAPPING), .NUM_CHANNELS(NUM_CHANNELS), .NUM_COLUMNS(NUM_COLUMNS),
        .NUM_ROWS(NUM_ROWS), .NUM_BG(NUM_BG), .NUM_BA(NUM_BA), .NUM_RANKS(NUM_RANKS)
    ) unmap_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .mem     (req_if.mapper)
    );

    channel_mem_array #(
        .NUM_CHANNELS(NUM_CHANNELS), .NUM_COLUMNS(NUM_COLUMNS), .NUM_ROWS(NUM_ROWS),
        .NUM_BG(NUM_BG), .NUM_BA(NUM_BA), .NUM_RANKS(NUM_RANKS)
    ) mem_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mem      (req_if.memory),
        .ch_act_o (ch_act_o)
    );

    a_geom_fits: assert property (@(posedge clk_i)
        (glob_addr_bits(NUM_CHANNELS, NUM_ROWS, NUM_RANKS, NUM_BG, NUM_BA, NUM_COLUMNS)
            == $bits(glob_addr_t))
        && (ch_addr_bits(NUM_ROWS, NUM_RANKS, NUM_BG, NUM_BA, NUM_COLUMNS)
            == $bits(ch_addr_t))
        && (field_bits(NUM_CHANNELS) <= $bits(ch_idx_t)));

endmodule

// ==== dv/tb_dram_model.sv ====
//////////////////////////////
// Runs MAP_RO_CH_RA_BA_BG_CO on the default geometry
// Every read in the table targets a word written earlier
//////////////////////////////
`timescale 1ns/1ps

module tb_dram_model;
    import wb_bus_pkg::*;

    localparam wb_addr_t GLOB_LIMIT = 32'd4096;  // 2**12 byte addresses
    localparam int       ACT_CYCLE  = 3;
    localparam int       ACK_CYCLE  = 4;
    localparam int       ERR_CYCLE  = 2;
    localparam int       MAX_WAIT   = 12;
    localparam wb_sel_t  SEL_PAT [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};

    typedef struct packed {
        logic     we;
        wb_addr_t addr;
        wb_data_t data;
        wb_sel_t  sel;
        wb_data_t exp_data;
        logic     exp_err;
        int       exp_ch;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    wb_sel_t    wb_sel;
    wb_data_t   wb_dat_r;
    logic       wb_ack;
    logic       wb_err;
    logic [1:0] ch_act;

    row_t     rows [$];
    wb_data_t ref_mem [2][512];  // Expected contents per channel and word
    integer   seed = 32'hfecb_ae1d;
    int       errors = 0;
    int       checks = 0;
    bit       table_ready = 1'b0;

    dram_model_top #(
        .MAPPING (dram_geom_pkg::MAP_RO_CH_RA_BA_BG_CO)
    ) dut_i (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .ch_act_o (ch_act)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Order from the top: row, channel, rank (0 bits), bank, bank group, column, offset
    function automatic int ref_channel(wb_addr_t a);
        return int'(a[8]);
    endfunction

    // Channel word packs row, bank group, bank, column
    function automatic int ref_word(wb_addr_t a);
        return int'({a[11:9], a[6], a[7], a[5:2]});
    endfunction

    task automatic add_row(input logic we, input wb_addr_t addr, input wb_data_t data,
                           input wb_sel_t sel);
        row_t     r;
        wb_data_t merged;
        int       ch;
        int       w;
        r.we       = we;
        r.addr     = addr;
        r.data     = data;
        r.sel      = sel;
        r.exp_data = '0;
        r.exp_err  = (addr >= GLOB_LIMIT);
        r.exp_ch   = 0;
        if (!r.exp_err) begin
            ch       = ref_channel(addr);
            w        = ref_word(addr);
            r.exp_ch = ch;
            if (we) begin
                merged = ref_mem[ch][w];
                for (int b = 0; b < 4; b++) begin
                    if (sel[b])
                        merged[8*b +: 8] = data[8*b +: 8];
                end
                ref_mem[ch][w] = merged;
            end else begin
                r.exp_data = ref_mem[ch][w];
            end
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        wb_addr_t base [8];
        wb_addr_t a;
        for (int i = 0; i < 8; i++) begin
            base[i] = $unsigned($random(seed)) & 32'h0000_0ffc;
            add_row(1'b1, base[i], $unsigned($random(seed)), 4'hf);
            add_row(1'b0, base[i], '0, 4'hf);
        end
        for (int i = 0; i < 4; i++) begin  // Partial lanes over known words
            add_row(1'b1, base[i], $unsigned($random(seed)), SEL_PAT[i]);
            add_row(1'b0, base[i], '0, 4'hf);
        end
        a = 32'h0000_0a4c;  // Channel bit clear
        add_row(1'b1, a, $unsigned($random(seed)), 4'hf);
        add_row(1'b1, a | 32'h100, $unsigned($random(seed)), 4'hf);
        add_row(1'b0, a, '0, 4'hf);
        add_row(1'b0, a | 32'h100, '0, 4'hf);
        for (int off = 1; off < 4; off++)
            add_row(1'b0, a + wb_addr_t'(off), '0, 4'hf);
        add_row(1'b1, a + 32'd3, $unsigned($random(seed)), 4'hf);
        add_row(1'b0, a, '0, 4'hf);
        // Out of range, low bits alias words that hold data
        add_row(1'b1, a + 32'h1000, $unsigned($random(seed)), 4'hf);
        add_row(1'b0, a, '0, 4'hf);
        add_row(1'b0, 32'hffff_fffc, '0, 4'hf);
        add_row(1'b1, 32'h0001_0000 | a | 32'h100, $unsigned($random(seed)), 4'hf);
        add_row(1'b0, a | 32'h100, '0, 4'hf);
    endtask

    // One classic transfer, ack/err and activity checked per cycle after E
    task automatic run_row(input row_t r);
        logic [1:0] act_exp;
        int         cyc;
        bit         done;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = r.we;
        wb_adr   = r.addr;
        wb_dat_w = r.data;
        wb_sel   = r.sel;
        done     = 1'b0;
        cyc      = 0;
        while (!done && cyc < MAX_WAIT) begin
            @(negedge clk);
            cyc++;
            act_exp = '0;
            if (!r.exp_err && cyc == ACT_CYCLE)
                act_exp[r.exp_ch] = 1'b1;
            check("ch_act_o", ch_act, act_exp);
            if (wb_ack || wb_err) begin
                done = 1'b1;
                check("wb_ack_o", wb_ack, !r.exp_err);
                check("wb_err_o", wb_err, r.exp_err);
                check("response cycle", cyc, r.exp_err ? ERR_CYCLE : ACK_CYCLE);
                if (!r.we && !r.exp_err)
                    check("wb_dat_o", wb_dat_r, r.exp_data);
            end
        end
        if (!done) begin
            errors++;
            $display("No ack or err came back for address %h within %0d cycles",
                     r.addr, MAX_WAIT);
        end
        @(negedge clk);  // Ack or err taken at the rising edge, termination one cycle wide
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        check("wb_ack_o", wb_ack, 1'b0);
        check("wb_err_o", wb_err, 1'b0);
        check("ch_act_o", ch_act, 2'b00);
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        rst_n    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check("wb_ack_o", wb_ack, 1'b0);
        check("wb_err_o", wb_err, 1'b0);
        check("ch_act_o", ch_act, 2'b00);
        rst_n = 1'b1;
        foreach (rows[i])
            run_row(rows[i]);
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // About six cycles per row, eight allowed
    initial begin
        wait (table_ready);
        repeat (rows.size() * 8 + 5 + 20) @(posedge clk);
        $display("Watchdog expired before the table was done");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/dram_geom_pkg.sv
rtl/wb_bus_pkg.sv
rtl/mem_req_if.sv
rtl/wb_slave_front.sv
rtl/addr_unmap.sv
rtl/channel_mem_array.sv
rtl/dram_model_top.sv
dv/tb_dram_model.sv

// ==== Makefile ====
# Verilator simulation of the DRAM model testbench
# sim fails unless the log holds the pass line

TOP := tb_dram_model

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
